//--- project.f
logic/ace_snoop_pkg.sv
logic/ccu_ctrl_pkg.sv
logic/cr_summary_if.sv
logic/ccu_fifo.sv
logic/ac_issue.sv
logic/cr_collect.sv
logic/cr_dispatch.sv
logic/ccu_snoop_ctrl.sv
sim/ccu_checker.sv
sim/tb_ccu_snoop_ctrl.sv

//--- sim/tb_ccu_snoop_ctrl.sv
module tb_ccu_snoop_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import ace_snoop_pkg::*;
    import ccu_ctrl_pkg::*;

    localparam int unsigned NumReq       = 80;
    localparam int unsigned CyclesPerReq = 200;
    localparam logic [31:0] Seed         = 32'he69e_11f6;

    // Names match the DUT ports so both instances connect by name
    logic                         clk_i, rst_ni;
    logic                         ar_valid_i, ar_ready_o;
    addr_t                        ar_addr_i, ac_addr_o, req_addr_o;
    id_t                          ar_id_i, req_id_o;
    snoop_t                       ar_snoop_i;
    port_mask_t                   ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    ac_snoop_t                    ac_snoop_o;
    cr_resp_t [NumPorts-1:0]      cr_resp_i;
    logic                         su_req_o, su_gnt_i, mu_req_o, mu_gnt_i;
    su_op_e                       su_op_o;
    mu_op_e                       mu_op_o;
    logic                         shared_o, dirty_o;
    port_mask_t                   data_available_o;
    port_idx_t                    first_responder_o;
    int unsigned                  err_count_o, done_count_o;
    logic [31:0]                  stim_lfsr, model_lfsr;
    logic                         slow;
    port_mask_t                   ac_fire, cr_fire;
    cr_resp_t                     cr_q [NumPorts][$];

    ccu_snoop_ctrl ccu_snoop_ctrl_i (.*);
    ccu_checker checker_i (.*);

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val   = {val[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
        end
        return val;
    endfunction

    function automatic logic ready_roll(inout logic [31:0] state, input logic slow_mode);
        if (slow_mode) begin
            return take_bits(state, 3) == 0;
        end
        return take_bits(state, 2) != 0;
    endfunction

    task automatic drive_request();
        logic [2:0]  pick;
        int unsigned gap;
        pick = take_bits(stim_lfsr, 3);
        case (pick)
            3'd0:    ar_snoop_i = ReadOnce;
            3'd1:    ar_snoop_i = ReadShared;
            3'd2:    ar_snoop_i = ReadClean;
            3'd3:    ar_snoop_i = ReadUnique;
            3'd6:    ar_snoop_i = ReadShared;
            3'd7:    ar_snoop_i = ReadUnique;
            default: ar_snoop_i = CleanUnique;
        endcase
        ar_id_i    = take_bits(stim_lfsr, IdWidth);
        ar_addr_i  = take_bits(stim_lfsr, 32);
        ar_valid_i = 1'b1;
        do @(negedge clk_i); while (!ar_ready_o);
        @(posedge clk_i);
        #1 ar_valid_i = 1'b0;
        // Back to back requests in the slow phase
        gap = slow ? 0 : take_bits(stim_lfsr, 2);
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        rst_ni     = 1'b0;
        ar_valid_i = 1'b0;
        ar_addr_i  = '0;
        ar_id_i    = '0;
        ar_snoop_i = '0;
        ac_ready_i = '0;
        cr_valid_i = '0;
        cr_resp_i  = '0;
        su_gnt_i   = 1'b0;
        mu_gnt_i   = 1'b0;
        slow       = 1'b0;
        ac_fire    = '0;
        cr_fire    = '0;
        stim_lfsr  = Seed;
        model_lfsr = Seed;
        repeat (8) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        for (int n = 0; n < NumReq; n++) begin
            slow = (n >= NumReq / 2);
            drive_request();
        end
        wait (done_count_o == NumReq);
        repeat (4) @(posedge clk_i);
        $display("Totals: %0d tests done, %0d errors", done_count_o, err_count_o);
        if (err_count_o == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(NumReq * CyclesPerReq * 10 + 200);
        $display("Watchdog expired with %0d of %0d requests retired", done_count_o, NumReq);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // Cache port and unit models
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin
        ac_fire = ac_valid_o & ac_ready_i;
        cr_fire = cr_valid_i & cr_ready_o;
    end

    always @(posedge clk_i) begin
        #1;
        for (int p = 0; p < NumPorts; p++) begin
            if (ac_fire[p]) begin
                cr_q[p].push_back(cr_resp_t'(take_bits(model_lfsr, CrRespWidth)));
            end
            if (cr_fire[p]) begin
                void'(cr_q[p].pop_front());
                cr_valid_i[p] = 1'b0;
            end
            // CR answers in AC order, held until taken
            if (!cr_valid_i[p] && cr_q[p].size() != 0 && ready_roll(model_lfsr, slow)) begin
                cr_valid_i[p] = 1'b1;
                cr_resp_i[p]  = cr_q[p][0];
            end
            ac_ready_i[p] = ready_roll(model_lfsr, slow);
        end
        su_gnt_i = ready_roll(model_lfsr, slow);
        mu_gnt_i = ready_roll(model_lfsr, slow);
    end

endmodule

//--- sim/ccu_checker.sv
module ccu_checker (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic                                                 ar_valid_i,
    input  logic                                                 ar_ready_o,
    input  ace_snoop_pkg::addr_t                                 ar_addr_i,
    input  ace_snoop_pkg::id_t                                   ar_id_i,
    input  ace_snoop_pkg::snoop_t                                ar_snoop_i,
    input  ccu_ctrl_pkg::port_mask_t                             ac_valid_o,
    input  ccu_ctrl_pkg::port_mask_t                             ac_ready_i,
    input  ace_snoop_pkg::addr_t                                 ac_addr_o,
    input  ace_snoop_pkg::ac_snoop_t                             ac_snoop_o,
    input  ccu_ctrl_pkg::port_mask_t                             cr_valid_i,
    input  ccu_ctrl_pkg::port_mask_t                             cr_ready_o,
    input  ace_snoop_pkg::cr_resp_t [ccu_ctrl_pkg::NumPorts-1:0] cr_resp_i,
    input  logic                                                 su_req_o,
    input  ccu_ctrl_pkg::su_op_e                                 su_op_o,
    input  logic                                                 su_gnt_i,
    input  logic                                                 mu_req_o,
    input  ccu_ctrl_pkg::mu_op_e                                 mu_op_o,
    input  logic                                                 mu_gnt_i,
    input  ace_snoop_pkg::addr_t                                 req_addr_o,
    input  ace_snoop_pkg::id_t                                   req_id_o,
    input  logic                                                 shared_o,
    input  logic                                                 dirty_o,
    input  ccu_ctrl_pkg::port_mask_t                             data_available_o,
    input  ccu_ctrl_pkg::port_idx_t                              first_responder_o,
    output int unsigned                                          err_count_o,
    output int unsigned                                          done_count_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import ace_snoop_pkg::*;
    import ccu_ctrl_pkg::*;

    typedef struct packed {
        logic       su_exp;
        su_op_e     su_op;
        logic       mu_exp;
        mu_op_e     mu_op;
        logic       shared;
        logic       dirty;
        port_mask_t avail;
        logic       data_ok;
        port_idx_t  first;
    } expect_t;

    typedef struct packed {
        addr_t  addr;
        id_t    id;
        snoop_t snoop;
    } req_t;

    req_t        pend_q [$];
    req_t        last_req;
    port_mask_t  last_init;
    ac_snoop_t   exp_snoop;
    int unsigned cycle, accepted, test_err;
    port_mask_t  ac_seen, cr_seen;
    cr_resp_t    resp [NumPorts];
    int unsigned arrival [NumPorts];
    logic        su_done, mu_done;

    initial begin
        err_count_o  = 0;
        done_count_o = 0;
        cycle        = 0;
        accepted     = 0;
        test_err     = 0;
        last_init    = '0;
        exp_snoop    = '0;
        ac_seen      = '0;
        cr_seen      = '0;
        su_done      = 1'b0;
        mu_done      = 1'b0;
    end

    function automatic port_mask_t initiator_mask(id_t id);
        return port_mask_t'(1) << id[IdWidth-1 -: PortIdxBits];
    endfunction

    // Expected dispatch from the request and the CR responses seen
    function automatic expect_t reference(snoop_t snoop, port_mask_t seen,
                                          cr_resp_t r [NumPorts], int unsigned arr [NumPorts]);
        expect_t     e;
        int unsigned best;
        e    = '0;
        best = 32'hffff_ffff;
        for (int i = 0; i < NumPorts; i++) begin
            if (seen[i]) begin
                e.avail[i] = r[i][CrDataTransfer];
                e.shared   |= r[i][CrIsShared];
                e.dirty    |= r[i][CrPassDirty];
                // Earliest clean data wins, lowest port on a tie
                if (r[i][CrDataTransfer] && !r[i][CrError] && arr[i] < best) begin
                    e.data_ok = 1'b1;
                    e.first   = port_idx_t'(i);
                    best      = arr[i];
                end
            end
        end
        if (snoop == CleanUnique) begin
            e.su_exp = 1'b1;
            e.su_op  = SU_INVALID_ACK_R;
            // Any supplied data is written back
            e.mu_exp = |e.avail;
            e.mu_op  = MU_WRITE_BACK_R;
        end else begin
            e.su_exp = e.data_ok;
            e.su_op  = SU_READ_SNP_DATA;
            e.mu_exp = !e.data_ok;
            e.mu_op  = MU_AXI_READ;
        end
        return e;
    endfunction

    task automatic compare_value(string test, string field, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected %h actual %h", test, field, exp, act);
            test_err++;
            err_count_o++;
        end
    endtask

    task automatic report_failure(string msg);
        $display("Check failed: %s", msg);
        test_err++;
        err_count_o++;
    endtask

    task automatic check_grant();
        string   name;
        expect_t e;
        if (pend_q.size() == 0) begin
            report_failure("unit grant with no request pending");
        end else begin
            name = $sformatf("req%0d", done_count_o);
            e    = reference(pend_q[0].snoop, cr_seen, resp, arrival);
            if (cr_seen != ~initiator_mask(pend_q[0].id)) begin
                report_failure($sformatf("%s dispatched before all snoop responses", name));
            end
            compare_value(name, "req_addr", pend_q[0].addr, req_addr_o);
            compare_value(name, "req_id", 32'(pend_q[0].id), 32'(req_id_o));
            compare_value(name, "shared", 32'(e.shared), 32'(shared_o));
            compare_value(name, "dirty", 32'(e.dirty), 32'(dirty_o));
            compare_value(name, "data_available", 32'(e.avail), 32'(data_available_o));
            if (e.data_ok) begin
                compare_value(name, "first_responder", 32'(e.first), 32'(first_responder_o));
            end
            if (su_req_o && su_gnt_i) begin
                if (!e.su_exp || su_done) begin
                    report_failure($sformatf("%s got an unexpected snoop unit grant", name));
                end
                compare_value(name, "su_op", 32'(e.su_op), 32'(su_op_o));
                su_done = 1'b1;
            end
            if (mu_req_o && mu_gnt_i) begin
                if (!e.mu_exp || mu_done) begin
                    report_failure($sformatf("%s got an unexpected memory unit grant", name));
                end
                compare_value(name, "mu_op", 32'(e.mu_op), 32'(mu_op_o));
                mu_done = 1'b1;
            end
            if (su_done == e.su_exp && mu_done == e.mu_exp) begin
                $display("%s snoop %h: %s", name, pend_q[0].snoop,
                         (test_err == 0) ? "ok" : "failed");
                void'(pend_q.pop_front());
                done_count_o++;
                test_err = 0;
                su_done  = 1'b0;
                mu_done  = 1'b0;
                cr_seen  = '0;
            end
        end
    endtask

    // Sampled at the falling edge, where all signals are settled
    always @(negedge clk_i) begin
        cycle++;
        if (accepted == 0 && (|ac_valid_o || |cr_ready_o || su_req_o || mu_req_o
                              || (ar_ready_o && !ar_valid_i))) begin
            report_failure("outputs active before the first request");
        end
        if (rst_ni) begin
            for (int p = 0; p < NumPorts; p++) begin
                if (ac_valid_o[p] && ac_ready_i[p]) begin
                    if (accepted == 0 || last_init[p] || ac_seen[p]) begin
                        report_failure($sformatf("unexpected AC transfer on port %0d", p));
                    end
                    ac_seen[p] = 1'b1;
                    compare_value($sformatf("req%0d", accepted - 1), "ac_addr",
                                  last_req.addr, ac_addr_o);
                    compare_value($sformatf("req%0d", accepted - 1), "ac_snoop",
                                  32'(exp_snoop), 32'(ac_snoop_o));
                end
            end
            if (pend_q.size() >= PendDepth && ar_ready_o) begin
                report_failure("request accepted while the pending queue is full");
            end
            if (ar_valid_i && ar_ready_o) begin
                if (accepted != 0 && (ac_seen | last_init) != '1) begin
                    report_failure("new request accepted before all AC transfers");
                end
                last_req  = '{addr: ar_addr_i, id: ar_id_i, snoop: ar_snoop_i};
                last_init = initiator_mask(ar_id_i);
                // CleanUnique is snooped as CleanInvalid
                exp_snoop = (ar_snoop_i == CleanUnique) ? CleanInvalid : ar_snoop_i;
                pend_q.push_back(last_req);
                accepted++;
                ac_seen = '0;
            end
            for (int p = 0; p < NumPorts; p++) begin
                if (cr_valid_i[p] && cr_ready_o[p]) begin
                    if (cr_seen[p] || pend_q.size() == 0) begin
                        report_failure($sformatf("extra CR transfer on port %0d", p));
                    end
                    cr_seen[p] = 1'b1;
                    resp[p]    = cr_resp_i[p];
                    arrival[p] = cycle;
                end
            end
            if ((su_req_o && su_gnt_i) || (mu_req_o && mu_gnt_i)) begin
                check_grant();
            end
        end
    end

endmodule

//--- logic/ccu_snoop_ctrl.sv
module ccu_snoop_ctrl (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic                                                 ar_valid_i,
    output logic                                                 ar_ready_o,
    input  ace_snoop_pkg::addr_t                                 ar_addr_i,
    input  ace_snoop_pkg::id_t                                   ar_id_i,
    input  ace_snoop_pkg::snoop_t                                ar_snoop_i,
    output ccu_ctrl_pkg::port_mask_t                             ac_valid_o,
    input  ccu_ctrl_pkg::port_mask_t                             ac_ready_i,
    output ace_snoop_pkg::addr_t                                 ac_addr_o,
    output ace_snoop_pkg::ac_snoop_t                             ac_snoop_o,
    input  ccu_ctrl_pkg::port_mask_t                             cr_valid_i,
    output ccu_ctrl_pkg::port_mask_t                             cr_ready_o,
    input  ace_snoop_pkg::cr_resp_t [ccu_ctrl_pkg::NumPorts-1:0] cr_resp_i,
    output logic                                                 su_req_o,
    output ccu_ctrl_pkg::su_op_e                                 su_op_o,
    input  logic                                                 su_gnt_i,
    output logic                                                 mu_req_o,
    output ccu_ctrl_pkg::mu_op_e                                 mu_op_o,
    input  logic                                                 mu_gnt_i,
    output ace_snoop_pkg::addr_t                                 req_addr_o,
    output ace_snoop_pkg::id_t                                   req_id_o,
    output logic                                                 shared_o,
    output logic                                                 dirty_o,
    output ccu_ctrl_pkg::port_mask_t                             data_available_o,
    output ccu_ctrl_pkg::port_idx_t                              first_responder_o
);
    import ace_snoop_pkg::*;
    import ccu_ctrl_pkg::*;

    logic       fifo_push, fifo_full, fifo_empty;
    pend_data_t fifo_in, fifo_head;
    addr_t      head_addr;
    id_t        head_id;
    pend_cmd_e  head_cmd;

    cr_summary_if sum_if ();

    ac_issue ac_issue_i (
        .clk_i, .rst_ni,
        .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i, .ar_snoop_i,
        .fifo_full_i (fifo_full),
        .push_o      (fifo_push),
        .push_data_o (fifo_in),
        .ac_valid_o, .ac_ready_i, .ac_addr_o, .ac_snoop_o
    );

    ccu_fifo #(
        .Width (PendWidth),
        .Depth (PendDepth)
    ) pend_fifo_i (
        .clk_i, .rst_ni,
        .push_i  (fifo_push),
        .data_i  (fifo_in),
        .pop_i   (sum_if.retire),
        .data_o  (fifo_head),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    // Head entry fields
    assign head_cmd  = pend_cmd_e'(fifo_head[$bits(pend_cmd_e)-1:0]);
    assign head_id   = fifo_head[$bits(pend_cmd_e) +: IdWidth];
    assign head_addr = fifo_head[PendWidth-1 -: AddrWidth];

    cr_collect cr_collect_i (
        .clk_i, .rst_ni,
        .head_id_i (head_id),
        .empty_i   (fifo_empty),
        .cr_valid_i, .cr_ready_o, .cr_resp_i,
        .sum       (sum_if)
    );

    cr_dispatch cr_dispatch_i (
        .clk_i, .rst_ni,
        .head_cmd_i (head_cmd),
        .empty_i    (fifo_empty),
        .sum        (sum_if),
        .su_req_o, .su_op_o, .su_gnt_i,
        .mu_req_o, .mu_op_o, .mu_gnt_i
    );

    assign req_addr_o        = head_addr;
    assign req_id_o          = head_id;
    assign shared_o          = sum_if.shared;
    assign dirty_o           = sum_if.dirty;
    assign data_available_o  = sum_if.data_avail;
    assign first_responder_o = sum_if.first_resp;

endmodule

//--- logic/cr_dispatch.sv
module cr_dispatch (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  ccu_ctrl_pkg::pend_cmd_e head_cmd_i,
    input  logic                    empty_i,
    cr_summary_if.dispatcher        sum,
    output logic                    su_req_o,
    output ccu_ctrl_pkg::su_op_e    su_op_o,
    input  logic                    su_gnt_i,
    output logic                    mu_req_o,
    output ccu_ctrl_pkg::mu_op_e    mu_op_o,
    input  logic                    mu_gnt_i
);
    import ccu_ctrl_pkg::*;

    logic su_done_q, su_done_d;
    logic mu_done_q, mu_done_d;
    logic su_fire, mu_fire;
    logic retire;

    assign su_fire = su_req_o && su_gnt_i;
    assign mu_fire = mu_req_o && mu_gnt_i;

    always_comb begin
        su_req_o = 1'b0;
        mu_req_o = 1'b0;
        su_op_o  = SU_READ_SNP_DATA;
        mu_op_o  = MU_AXI_READ;
        retire   = 1'b0;

        if (!empty_i && sum.all_resp) begin
            case (head_cmd_i)
                CMD_RESP_R: begin
                    // Snoop hit goes to the snoop unit, miss to memory
                    su_req_o = sum.data_ok;
                    mu_req_o = !sum.data_ok;
                    retire   = su_fire || mu_fire;
                end
                CMD_INVALID_R: begin
                    su_op_o  = SU_INVALID_ACK_R;
                    su_req_o = !su_done_q;
                    // Write back whenever any port passed data
                    if (|sum.data_avail) begin
                        mu_op_o  = MU_WRITE_BACK_R;
                        mu_req_o = !mu_done_q;
                        retire   = (su_done_q || su_fire) && (mu_done_q || mu_fire);
                    end else begin
                        retire = su_fire;
                    end
                end
                default: retire = 1'b0;
            endcase
        end
    end

    // Grants already taken for the head entry
    assign su_done_d = retire ? 1'b0 : (su_done_q || su_fire);
    assign mu_done_d = retire ? 1'b0 : (mu_done_q || mu_fire);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            su_done_q <= 1'b0;
            mu_done_q <= 1'b0;
        end else begin
            su_done_q <= su_done_d;
            mu_done_q <= mu_done_d;
        end
    end

    assign sum.retire = retire;

endmodule

//--- logic/cr_collect.sv
module cr_collect (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  ace_snoop_pkg::id_t                                   head_id_i,
    input  logic                                                 empty_i,
    input  ccu_ctrl_pkg::port_mask_t                             cr_valid_i,
    output ccu_ctrl_pkg::port_mask_t                             cr_ready_o,
    input  ace_snoop_pkg::cr_resp_t [ccu_ctrl_pkg::NumPorts-1:0] cr_resp_i,
    cr_summary_if.collector                                      sum
);
    import ace_snoop_pkg::*;
    import ccu_ctrl_pkg::*;

    port_mask_t init_mask, cr_hs;
    port_mask_t hs_q, data_q, err_q, shared_q, dirty_q;
    logic       all_resp_q;
    logic       found_q;
    port_idx_t  first_q;
    logic       hit_found;
    port_idx_t  hit_idx;

    assign init_mask  = port_mask_t'(1) << head_id_i[IdWidth-1 -: PortIdxBits];
    assign cr_ready_o = empty_i ? '0 : ~(hs_q | init_mask);
    assign cr_hs      = cr_valid_i & cr_ready_o;

    // Lowest port with clean data this cycle
    always_comb begin
        hit_found = 1'b0;
        hit_idx   = '0;
        for (int i = NumPorts - 1; i >= 0; i--) begin
            if (cr_hs[i] && cr_resp_i[i][CrDataTransfer] && !cr_resp_i[i][CrError]) begin
                hit_found = 1'b1;
                hit_idx   = port_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hs_q       <= '0;
            data_q     <= '0;
            err_q      <= '0;
            shared_q   <= '0;
            dirty_q    <= '0;
            all_resp_q <= 1'b0;
            found_q    <= 1'b0;
            first_q    <= '0;
        end else if (sum.retire) begin
            // Head entry leaves, start over for the next one
            hs_q       <= '0;
            data_q     <= '0;
            err_q      <= '0;
            shared_q   <= '0;
            dirty_q    <= '0;
            all_resp_q <= 1'b0;
            found_q    <= 1'b0;
            first_q    <= '0;
        end else begin
            for (int i = 0; i < NumPorts; i++) begin
                if (cr_hs[i]) begin
                    hs_q[i]     <= 1'b1;
                    data_q[i]   <= cr_resp_i[i][CrDataTransfer];
                    err_q[i]    <= cr_resp_i[i][CrError];
                    shared_q[i] <= cr_resp_i[i][CrIsShared];
                    dirty_q[i]  <= cr_resp_i[i][CrPassDirty];
                end
            end
            all_resp_q <= !empty_i && (&(hs_q | cr_hs | init_mask));
            if (!found_q && hit_found) begin
                found_q <= 1'b1;
                first_q <= hit_idx;
            end
        end
    end

    assign sum.all_resp   = all_resp_q;
    assign sum.data_ok    = |(data_q & ~err_q);
    assign sum.shared     = |shared_q;
    assign sum.dirty      = |dirty_q;
    assign sum.data_avail = data_q;
    assign sum.first_resp = first_q;

endmodule

//--- logic/ac_issue.sv
module ac_issue (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      ar_valid_i,
    output logic                      ar_ready_o,
    input  ace_snoop_pkg::addr_t      ar_addr_i,
    input  ace_snoop_pkg::id_t        ar_id_i,
    input  ace_snoop_pkg::snoop_t     ar_snoop_i,
    input  logic                      fifo_full_i,
    output logic                      push_o,
    output ccu_ctrl_pkg::pend_data_t  push_data_o,
    output ccu_ctrl_pkg::port_mask_t  ac_valid_o,
    input  ccu_ctrl_pkg::port_mask_t  ac_ready_i,
    output ace_snoop_pkg::addr_t      ac_addr_o,
    output ace_snoop_pkg::ac_snoop_t  ac_snoop_o
);
    import ace_snoop_pkg::*;
    import ccu_ctrl_pkg::*;

    typedef enum logic {
        AC_IDLE,
        AC_BUSY
    } ac_state_e;

    ac_state_e  state_q, state_d;
    port_mask_t hs_q, hs_d;
    port_mask_t ac_hs;
    port_mask_t init_mask;
    addr_t      addr_q;
    ac_snoop_t  snoop_q, snoop_map;
    pend_cmd_e  cmd_map;
    logic       ac_done;
    logic       idle;

    // Initiator sits in the top ID bits
    assign init_mask = port_mask_t'(1) << ar_id_i[IdWidth-1 -: PortIdxBits];

    always_comb begin
        if (ar_snoop_i == CleanUnique) begin
            snoop_map = CleanInvalid;
            cmd_map   = CMD_INVALID_R;
        end else begin
            snoop_map = ar_snoop_i;
            cmd_map   = CMD_RESP_R;
        end
    end

    assign ac_valid_o  = (state_q == AC_BUSY) ? ~hs_q : '0;
    assign ac_hs       = ac_valid_o & ac_ready_i;
    assign ac_done     = &(hs_q | ac_hs);
    assign idle        = (state_q == AC_IDLE) || ac_done;
    assign ar_ready_o  = ar_valid_i && idle && !fifo_full_i;
    assign push_o      = ar_valid_i && ar_ready_o;
    assign push_data_o = {ar_addr_i, ar_id_i, cmd_map};
    assign ac_addr_o   = addr_q;
    assign ac_snoop_o  = snoop_q;

    // ------------------------------------------------------------------
    // AC broadcast FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        hs_d    = hs_q | ac_hs;
        if (push_o) begin
            state_d = AC_BUSY;
            hs_d    = init_mask;
        end else if (idle) begin
            state_d = AC_IDLE;
            hs_d    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= AC_IDLE;
            hs_q    <= '0;
        end else begin
            state_q <= state_d;
            hs_q    <= hs_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_o) begin
            addr_q  <= ar_addr_i;
            snoop_q <= snoop_map;
        end
    end

endmodule

//--- logic/ccu_fifo.sv
module ccu_fifo #(
    parameter int unsigned Width = 8,
    parameter int unsigned Depth = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_i,
    input  logic [Width-1:0] data_i,
    input  logic             pop_i,
    output logic [Width-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntBits = $clog2(Depth + 1);

    logic [Width-1:0]   mem_q [Depth];
    logic [PtrBits-1:0] rd_ptr_q, wr_ptr_q;
    logic [CntBits-1:0] count_q;
    logic               do_push, do_pop;

    assign full_o  = (count_q == CntBits'(Depth));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PtrBits'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrBits'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- logic/cr_summary_if.sv
interface cr_summary_if;
    import ccu_ctrl_pkg::*;

    logic       all_resp;
    logic       data_ok;
    logic       shared;
    logic       dirty;
    port_mask_t data_avail;
    port_idx_t  first_resp;
    logic       retire;

    modport collector (
        output all_resp, data_ok, shared, dirty, data_avail, first_resp,
        input  retire
    );

    modport dispatcher (
        input  all_resp, data_ok, shared, dirty, data_avail, first_resp,
        output retire
    );

endinterface

//--- logic/ccu_ctrl_pkg.sv
package ccu_ctrl_pkg;

    // Cache ports and pending queue
    localparam int unsigned NumPorts    = 4;
    localparam int unsigned PortIdxBits = $clog2(NumPorts);
    localparam int unsigned PendDepth   = 4;

    typedef logic [NumPorts-1:0]    port_mask_t;
    typedef logic [PortIdxBits-1:0] port_idx_t;

    // Command stored with each pending read
    typedef enum logic {
        CMD_RESP_R,
        CMD_INVALID_R
    } pend_cmd_e;

    // Snoop unit operations
    typedef enum logic {
        SU_READ_SNP_DATA,
        SU_INVALID_ACK_R
    } su_op_e;

    // Memory unit operations
    typedef enum logic {
        MU_AXI_READ,
        MU_WRITE_BACK_R
    } mu_op_e;

    // Pending entry is {addr, id, cmd}
    localparam int unsigned PendWidth = ace_snoop_pkg::AddrWidth
                                      + ace_snoop_pkg::IdWidth
                                      + $bits(pend_cmd_e);

    typedef logic [PendWidth-1:0] pend_data_t;

endpackage

//--- logic/ace_snoop_pkg.sv
package ace_snoop_pkg;

    // Request field widths
    localparam int unsigned AddrWidth   = 32;
    localparam int unsigned IdWidth     = 6;
    localparam int unsigned SnoopWidth  = 4;
    localparam int unsigned CrRespWidth = 5;

    typedef logic [AddrWidth-1:0]   addr_t;
    typedef logic [IdWidth-1:0]     id_t;
    typedef logic [SnoopWidth-1:0]  snoop_t;
    typedef logic [SnoopWidth-1:0]  ac_snoop_t;
    typedef logic [CrRespWidth-1:0] cr_resp_t;

    // ARSNOOP codes for shareable read transactions
    localparam snoop_t ReadOnce    = 4'b0000;
    localparam snoop_t ReadShared  = 4'b0001;
    localparam snoop_t ReadClean   = 4'b0010;
    localparam snoop_t ReadUnique  = 4'b0111;
    localparam snoop_t CleanUnique = 4'b1011;

    // ACSNOOP code, the read codes above are shared with AC
    localparam ac_snoop_t CleanInvalid = 4'b1001;

    // CRRESP bit positions
    localparam int unsigned CrDataTransfer = 0;
    localparam int unsigned CrError        = 1;
    localparam int unsigned CrPassDirty    = 2;
    localparam int unsigned CrIsShared     = 3;
    localparam int unsigned CrWasUnique    = 4;

endpackage
